//--- adc_timing_pkg.sv
// AD7606 timing in usr_clk cycles (25 MHz) and static pin levels, shared by all controller blocks.
package adc_timing_pkg;

    // **************************************************
    // clock and chip timing, in usr_clk cycles
    // **************************************************
    localparam int clk_period_ns        = 40;  // usr_clk at 25 MHz.
    localparam int reset_pulse_clks     = 2;   // RESET high time.
    localparam int convst_low_clks      = 1;   // CONVST low time.
    localparam int busy_rise_min_clks   = 1;   // earliest accepted BUSY high.
    localparam int busy_rise_max_clks   = 4;   // BUSY still low here is a fault.
    localparam int conv_max_clks        = 117; // worst case conversion plus margin.
    localparam int rd_low_clks          = 2;   // RD# low before sampling the word.
    localparam int rd_high_clks         = 1;   // RD# high between words.
    localparam int first_data_wait_clks = 4;   // extra wait for FIRSTDATA on word 1.

    // **************************************************
    // counter and frame sizes
    // **************************************************
    localparam int timer_width  = 8;  // every down counter.
    localparam int num_channels = 8;

    // static pin levels, driven straight out of the top level
    localparam int       pin_range   = 1;    // +/-10 V range.
    localparam logic [2:0] pin_os    = 3'd0; // no oversampling.
    localparam int       pin_par_sel = 0;    // parallel interface.
    localparam int       pin_stby_n  = 1;    // normal operation.

endpackage

//--- adc_types_pkg.sv
// Data types for AD7606 samples, the synchronized pin bundle and the eight-channel result frame.
package adc_types_pkg;

    // **************************************************
    // sample words
    // **************************************************
    typedef logic [15:0] sample_t;  // one channel, two's complement.
    typedef logic [2:0]  chan_idx_t; // channel 1 is index 0.

    // chip outputs after the two-flop synchronizer
    typedef struct packed {
        logic    busy;       // conversion in progress.
        logic    first_data; // high while channel 1 is on the bus.
        sample_t data;       // DB15..DB0.
    } adc_pins_t;

    // **************************************************
    // result frame
    // **************************************************
    // channel 1 sits in the low word
    typedef sample_t [adc_timing_pkg::num_channels-1:0] adc_frame_t;

endpackage

//--- adc_pin_sync.sv
// Synchronizes the AD7606 status and data pins to usr_clk and detects the user trigger edge.
`timescale 1ns/1ns

module adc_pin_sync (
    input  logic                     usr_clk,
    input  logic                     usr_rst,
    input  logic                     usr_trigger,
    input  logic                     hw_busy,
    input  logic                     hw_first_data,
    input  adc_types_pkg::sample_t   hw_data,
    output adc_types_pkg::adc_pins_t pins,
    output logic                     trig_rise
);

    import adc_types_pkg::*;

    adc_pins_t  pins_meta; // first synchronizer stage.
    logic [2:0] trig_sync; // two sync stages plus history.

    // **************************************************
    // chip pins, two flops each
    // **************************************************
    always_ff @(posedge usr_clk or negedge usr_rst) begin
        if (!usr_rst) begin
            pins_meta <= '0;
            pins      <= '0; // busy and first_data idle low.
        end else begin
            pins_meta <= '{busy: hw_busy, first_data: hw_first_data, data: hw_data};
            pins      <= pins_meta;
        end
    end

    // **************************************************
    // trigger edge
    // **************************************************
    always_ff @(posedge usr_clk or negedge usr_rst) begin
        if (!usr_rst) begin
            trig_sync <= '0;
        end else begin
            trig_sync <= {trig_sync[1:0], usr_trigger};
        end
    end

    assign trig_rise = trig_sync[1] & ~trig_sync[2]; // one cycle per edge.

endmodule

//--- adc_reset_seq.sv
// Drives the AD7606 RESET pulse after usr_rst or a fault and reports when the chip is ready.
`timescale 1ns/1ns

module adc_reset_seq (
    input  logic usr_clk,
    input  logic usr_rst,
    input  logic fault,
    output logic hw_reset,
    output logic ready
);

    import adc_timing_pkg::*;

    typedef enum logic [1:0] {st_pulse, st_settle, st_done} state_t;

    state_t                 state;
    logic [timer_width-1:0] cnt; // remaining pulse cycles.

    always_ff @(posedge usr_clk or negedge usr_rst) begin
        if (!usr_rst) begin
            state    <= st_pulse;
            cnt      <= timer_width'(reset_pulse_clks);
            hw_reset <= 1'b0;
            ready    <= 1'b0;
        end else if (fault) begin
            state    <= st_pulse; // pulse starts again next cycle.
            cnt      <= timer_width'(reset_pulse_clks);
            hw_reset <= 1'b0;
            ready    <= 1'b0;
        end else begin
            case (state)
                st_pulse: begin
                    if (cnt == '0) begin
                        hw_reset <= 1'b0;
                        state    <= st_settle;
                    end else begin
                        hw_reset <= 1'b1;
                        cnt      <= cnt - 1'b1;
                    end
                end
                st_settle: begin
                    ready <= 1'b1; // one cycle after RESET falls.
                    state <= st_done;
                end
                st_done: ;
                default: state <= st_pulse;
            endcase
        end
    end

    a_ready_excl_reset: assert property (@(posedge usr_clk) disable iff (!usr_rst)
        !(ready && hw_reset));

endmodule

//--- adc_conv_seq.sv
// Conversion sequencer for the AD7606: CONVST and CS# control, BUSY checks and the user status flags.
`timescale 1ns/1ns

module adc_conv_seq (
    input  logic usr_clk,
    input  logic usr_rst,
    input  logic trig_rise,
    input  logic ready,
    input  logic busy,
    input  logic read_done,
    input  logic read_fault,
    output logic hw_convst,
    output logic hw_cs,
    output logic read_start,
    output logic fault,
    output logic usr_sampling,
    output logic usr_error_occur
);

    import adc_timing_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_convst,
        st_wait_hi,
        st_wait_lo,
        st_reading
    } state_t;

    state_t                 state;
    logic [timer_width-1:0] cnt;       // per-state down counter.
    logic                   own_fault; // BUSY timeout in either direction.

    assign own_fault = (cnt == '0) &&
                       (((state == st_wait_hi) && !busy) || ((state == st_wait_lo) && busy));
    assign fault     = own_fault || read_fault;

    // **************************************************
    // sequencer
    // **************************************************
    always_ff @(posedge usr_clk or negedge usr_rst) begin
        if (!usr_rst) begin
            state           <= st_idle;
            cnt             <= '0;
            hw_convst       <= 1'b1;
            hw_cs           <= 1'b1;
            read_start      <= 1'b0;
            usr_sampling    <= 1'b0;
            usr_error_occur <= 1'b0;
        end else begin
            read_start <= 1'b0;
            if (fault) begin
                state           <= st_idle;
                hw_convst       <= 1'b1;
                hw_cs           <= 1'b1;
                usr_sampling    <= 1'b0;
                usr_error_occur <= 1'b1; // held until the next accepted trigger.
            end else begin
                case (state)
                    st_idle: begin
                        if (trig_rise && ready) begin
                            hw_cs           <= 1'b0;
                            hw_convst       <= 1'b0;
                            usr_sampling    <= 1'b1;
                            usr_error_occur <= 1'b0;
                            cnt             <= timer_width'(convst_low_clks - 1);
                            state           <= st_convst;
                        end
                    end
                    st_convst: begin
                        if (cnt == '0) begin
                            hw_convst <= 1'b1; // rising edge starts the conversion.
                            cnt       <= timer_width'(busy_rise_max_clks);
                            state     <= st_wait_hi;
                        end else begin
                            cnt <= cnt - 1'b1;
                        end
                    end
                    st_wait_hi: begin
                        // busy counts only after the minimum delay.
                        if (busy && (cnt <= timer_width'(busy_rise_max_clks - busy_rise_min_clks)))
                        begin
                            cnt   <= timer_width'(conv_max_clks);
                            state <= st_wait_lo;
                        end else begin
                            cnt <= cnt - 1'b1;
                        end
                    end
                    st_wait_lo: begin
                        if (!busy) begin
                            read_start <= 1'b1; // results are ready.
                            state      <= st_reading;
                        end else begin
                            cnt <= cnt - 1'b1;
                        end
                    end
                    st_reading: begin
                        if (read_done) begin
                            hw_cs        <= 1'b1;
                            usr_sampling <= 1'b0;
                            state        <= st_idle;
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    a_convst_in_cs: assert property (@(posedge usr_clk) disable iff (!usr_rst)
        !hw_convst |-> !hw_cs);

    a_no_fault_idle: assert property (@(posedge usr_clk) disable iff (!usr_rst)
        (state == st_idle) |-> !fault);

endmodule

//--- adc_chan_reader.sv
// Reads the eight AD7606 channel words with RD# pulses, checks FIRSTDATA and builds the result frame.
`timescale 1ns/1ns

module adc_chan_reader (
    input  logic                      usr_clk,
    input  logic                      usr_rst,
    input  logic                      read_start,
    input  logic                      fault,
    input  adc_types_pkg::adc_pins_t  pins,
    output logic                      hw_rd,
    output logic                      read_done,
    output logic                      read_fault,
    output adc_types_pkg::adc_frame_t frame
);

    import adc_timing_pkg::*;
    import adc_types_pkg::*;

    typedef enum logic [1:0] {st_idle, st_rd_low, st_sample, st_rd_high} state_t;

    state_t                 state;
    logic [timer_width-1:0] cnt;
    chan_idx_t              idx;        // word being read.
    logic                   first_word;
    logic                   word_ok;    // FIRSTDATA matches the word position.

    assign first_word = (idx == '0);
    assign word_ok    = first_word ? pins.first_data : !pins.first_data;

    // word 1 may wait for FIRSTDATA, later words may not
    assign read_fault = (state == st_sample) && !word_ok && (!first_word || (cnt == '0));

    // **************************************************
    // RD# pulses and capture
    // **************************************************
    always_ff @(posedge usr_clk or negedge usr_rst) begin
        if (!usr_rst) begin
            state     <= st_idle;
            cnt       <= '0;
            idx       <= '0;
            hw_rd     <= 1'b1;
            read_done <= 1'b0;
            frame     <= '0;
        end else begin
            read_done <= 1'b0;
            if (fault) begin
                state <= st_idle;
                idx   <= '0;
                hw_rd <= 1'b1;
                frame <= '0; // a broken frame is never shown.
            end else begin
                case (state)
                    st_idle: begin
                        if (read_start) begin
                            hw_rd <= 1'b0;
                            idx   <= '0;
                            cnt   <= timer_width'(rd_low_clks - 1);
                            state <= st_rd_low;
                        end
                    end
                    st_rd_low: begin
                        if (cnt == '0) begin
                            cnt   <= timer_width'(first_data_wait_clks);
                            state <= st_sample;
                        end else begin
                            cnt <= cnt - 1'b1;
                        end
                    end
                    st_sample: begin
                        if (word_ok) begin
                            frame[idx] <= pins.data;
                            hw_rd      <= 1'b1;
                            idx        <= idx + 1'b1; // wraps to 0 after channel 8.
                            if (idx == chan_idx_t'(num_channels - 1)) begin
                                read_done <= 1'b1;
                                state     <= st_idle;
                            end else begin
                                cnt   <= timer_width'(rd_high_clks - 1);
                                state <= st_rd_high;
                            end
                        end else begin
                            cnt <= cnt - 1'b1; // still waiting on FIRSTDATA.
                        end
                    end
                    st_rd_high: begin
                        if (cnt == '0) begin
                            hw_rd <= 1'b0;
                            cnt   <= timer_width'(rd_low_clks - 1);
                            state <= st_rd_low;
                        end else begin
                            cnt <= cnt - 1'b1;
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    a_rd_idle_high: assert property (@(posedge usr_clk) disable iff (!usr_rst)
        (state == st_idle) |-> hw_rd);

    a_start_when_idle: assert property (@(posedge usr_clk) disable iff (!usr_rst)
        read_start |-> (state == st_idle));

endmodule

//--- ad7606_ctrl.sv
// Top level of the AD7606 parallel-bus controller; wires the blocks and ties off the static chip pins.
`timescale 1ns/1ns

module ad7606_ctrl (
    input  logic                      usr_clk,
    input  logic                      usr_rst,
    input  logic                      usr_trigger,
    input  logic                      hw_busy,
    input  logic                      hw_first_data,
    input  adc_types_pkg::sample_t    hw_data,
    output logic                      hw_convst,
    output logic                      hw_cs,
    output logic                      hw_rd,
    output logic                      hw_reset,
    output logic                      hw_range,
    output logic [2:0]                hw_os,
    output logic                      hw_par_sel,
    output logic                      hw_stby_n,
    output adc_types_pkg::adc_frame_t usr_frame,
    output logic                      usr_sampling,
    output logic                      usr_error_occur,
    output logic                      usr_ready
);

    import adc_timing_pkg::*;
    import adc_types_pkg::*;

    adc_pins_t pins;       // synchronized chip outputs.
    logic      trig_rise;
    logic      read_start;
    logic      read_done;
    logic      read_fault;
    logic      fault;      // any sequencer or reader fault.
    logic      ready;

    // **************************************************
    // static pins
    // **************************************************
    assign hw_range   = 1'(pin_range);
    assign hw_os      = pin_os;
    assign hw_par_sel = 1'(pin_par_sel);
    assign hw_stby_n  = 1'(pin_stby_n);

    assign usr_ready = ready;

    adc_pin_sync adc_pin_sync_inst (
        .usr_clk       (usr_clk),
        .usr_rst       (usr_rst),
        .usr_trigger   (usr_trigger),
        .hw_busy       (hw_busy),
        .hw_first_data (hw_first_data),
        .hw_data       (hw_data),
        .pins          (pins),
        .trig_rise     (trig_rise)
    );

    adc_reset_seq adc_reset_seq_inst (
        .usr_clk  (usr_clk),
        .usr_rst  (usr_rst),
        .fault    (fault),
        .hw_reset (hw_reset),
        .ready    (ready)
    );

    adc_conv_seq adc_conv_seq_inst (
        .usr_clk         (usr_clk),
        .usr_rst         (usr_rst),
        .trig_rise       (trig_rise),
        .ready           (ready),
        .busy            (pins.busy),
        .read_done       (read_done),
        .read_fault      (read_fault),
        .hw_convst       (hw_convst),
        .hw_cs           (hw_cs),
        .read_start      (read_start),
        .fault           (fault),
        .usr_sampling    (usr_sampling),
        .usr_error_occur (usr_error_occur)
    );

    adc_chan_reader adc_chan_reader_inst (
        .usr_clk    (usr_clk),
        .usr_rst    (usr_rst),
        .read_start (read_start),
        .fault      (fault),
        .pins       (pins),
        .hw_rd      (hw_rd),
        .read_done  (read_done),
        .read_fault (read_fault),
        .frame      (usr_frame)
    );

endmodule

//--- tb_ad7606_ctrl.sv
// Self-checking testbench for the AD7606 controller with a behavioral chip model; top of all.f.
`timescale 1ns/1ns

module tb_ad7606_ctrl;

    import adc_timing_pkg::*;
    import adc_types_pkg::*;

    localparam int sel_ready    = 0;
    localparam int sel_sampling = 1;
    localparam int sel_error    = 2;
    localparam int sel_busy     = 3;

    logic       usr_clk       = 1'b0;
    logic       usr_rst       = 1'b0;
    logic       usr_trigger   = 1'b0;
    logic       hw_busy       = 1'b0;
    logic       hw_first_data = 1'b0;
    sample_t    hw_data       = '0;
    logic       hw_convst;
    logic       hw_cs;
    logic       hw_rd;
    logic       hw_reset;
    logic       hw_range;
    logic [2:0] hw_os;
    logic       hw_par_sel;
    logic       hw_stby_n;
    adc_frame_t usr_frame;
    logic       usr_sampling;
    logic       usr_error_occur;
    logic       usr_ready;

    logic rst_req  = 1'b0; // applied on the next rising edge.
    logic trig_req = 1'b0;

    // **************************************************
    // chip model state and fault knobs
    // **************************************************
    logic        prev_convst    = 1'b1;
    logic        prev_rd        = 1'b1;
    logic [31:0] rand_state     = 32'h83a9;
    int          busy_left      = 0;
    logic [3:0]  words_sent     = 4'd0;
    adc_frame_t  exp_frame      = '0;   // words as put on the bus.
    logic        no_busy_rise   = 1'b0;
    logic        busy_stuck     = 1'b0;
    logic        no_first_data  = 1'b0;
    logic        fault_expected = 1'b0;

    int cycles    = 0;
    int rst_len   = 0; // consecutive cycles of each level.
    int cv_len    = 0;
    int rd_len    = 0;
    int rd_pulses = 0; // RD# falls since the last CONVST.
    int err_cnt   = 0;
    int timeouts  = 0;

    ad7606_ctrl ad7606_ctrl_inst (
        .usr_clk         (usr_clk),
        .usr_rst         (usr_rst),
        .usr_trigger     (usr_trigger),
        .hw_busy         (hw_busy),
        .hw_first_data   (hw_first_data),
        .hw_data         (hw_data),
        .hw_convst       (hw_convst),
        .hw_cs           (hw_cs),
        .hw_rd           (hw_rd),
        .hw_reset        (hw_reset),
        .hw_range        (hw_range),
        .hw_os           (hw_os),
        .hw_par_sel      (hw_par_sel),
        .hw_stby_n       (hw_stby_n),
        .usr_frame       (usr_frame),
        .usr_sampling    (usr_sampling),
        .usr_error_occur (usr_error_occur),
        .usr_ready       (usr_ready)
    );

    initial begin
        forever #(clk_period_ns / 2) usr_clk = ~usr_clk;
    end

    always @(posedge usr_clk) begin
        usr_rst     <= rst_req;
        usr_trigger <= trig_req;
    end

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // **************************************************
    // chip model
    // **************************************************
    always @(posedge usr_clk) begin
        prev_convst <= hw_convst;
        prev_rd     <= hw_rd;
        if (hw_reset) begin
            hw_busy       <= 1'b0; // chip reset aborts everything.
            hw_first_data <= 1'b0;
            words_sent    <= 4'd0;
        end else if (!prev_convst && hw_convst) begin
            hw_busy    <= !no_busy_rise;
            busy_left  <= 20 + int'(rand_state[19:16]);
            rand_state <= next_rand(rand_state);
        end else if (hw_busy && !busy_stuck) begin
            busy_left <= busy_left - 1;
            if (busy_left == 0) begin
                hw_busy       <= 1'b0;
                hw_data       <= rand_state[31:16]; // channel 1 right away.
                hw_first_data <= !no_first_data;
                exp_frame[0]  <= rand_state[31:16];
                rand_state    <= next_rand(rand_state);
                words_sent    <= 4'd1;
            end
        end else if (!prev_rd && hw_rd && words_sent < 4'd8) begin
            hw_data                    <= rand_state[31:16]; // next channel.
            hw_first_data              <= 1'b0;
            exp_frame[words_sent[2:0]] <= rand_state[31:16];
            rand_state                 <= next_rand(rand_state);
            words_sent                 <= words_sent + 4'd1;
        end
    end

    always @(posedge usr_clk) begin
        cycles  <= cycles + 1;
        rst_len <= hw_reset ? rst_len + 1 : 0;
        cv_len  <= hw_convst ? 0 : cv_len + 1;
        rd_len  <= hw_rd ? 0 : rd_len + 1;
        if (prev_convst && !hw_convst) begin
            rd_pulses <= 0;
        end else if (prev_rd && !hw_rd) begin
            rd_pulses <= rd_pulses + 1;
        end
    end

    task automatic report_value(input string name, input logic [127:0] expected,
                                input logic [127:0] actual);
        err_cnt++;
        $display("error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
    endtask

    task automatic report_fail(input string what);
        err_cnt++;
        $display("check failed at %0t ns: %s", $time, what);
    endtask

    // **************************************************
    // checks
    // **************************************************
    a_idle_in_reset: assert property (@(posedge usr_clk) (!usr_rst && cycles > 0) |->
        (hw_convst && hw_cs && hw_rd && !hw_reset && !usr_sampling && !usr_error_occur &&
         !usr_ready && usr_frame == '0))
        else report_fail("outputs not inactive while usr_rst is low");
    a_static_pins: assert property (@(posedge usr_clk)
        {hw_range, hw_os, hw_par_sel, hw_stby_n} == 6'b1_000_0_1)
        else report_value("{hw_range, hw_os, hw_par_sel, hw_stby_n}", 128'(6'b1_000_0_1),
                          128'($sampled({hw_range, hw_os, hw_par_sel, hw_stby_n})));
    a_reset_len: assert property (@(posedge usr_clk) disable iff (!usr_rst)
        $fell(hw_reset) |-> rst_len == reset_pulse_clks)
        else report_value("hw_reset high cycles", 128'(reset_pulse_clks), 128'($sampled(rst_len)));
    a_ready_after: assert property (@(posedge usr_clk) disable iff (!usr_rst)
        $rose(usr_ready) |-> (!$past(hw_reset) && $past(hw_reset, 2)))
        else report_fail("usr_ready did not rise one cycle after hw_reset fell");
    a_convst_len: assert property (@(posedge usr_clk) disable iff (!usr_rst)
        $rose(hw_convst) |-> cv_len == convst_low_clks)
        else report_value("hw_convst low cycles", 128'(convst_low_clks), 128'($sampled(cv_len)));
    a_convst_cs: assert property (@(posedge usr_clk) disable iff (!usr_rst)
        !hw_convst |-> !hw_cs)
        else report_fail("hw_convst low while hw_cs is high");
    a_rd_len: assert property (@(posedge usr_clk) disable iff (!usr_rst)
        $rose(hw_rd) |-> rd_len >= rd_low_clks)
        else report_fail("RD# low pulse shorter than rd_low_clks");
    a_no_retrigger: assert property (@(posedge usr_clk) disable iff (!usr_rst)
        $fell(hw_convst) |-> !$past(usr_sampling))
        else report_fail("CONVST pulse started during a conversion");
    a_end_flag: assert property (@(posedge usr_clk) disable iff (!usr_rst)
        $fell(usr_sampling) |-> usr_error_occur == fault_expected)
        else report_value("usr_error_occur", 128'($sampled(fault_expected)),
                          128'($sampled(usr_error_occur)));
    a_end_frame: assert property (@(posedge usr_clk) disable iff (!usr_rst)
        $fell(usr_sampling) |-> usr_frame == (fault_expected ? '0 : exp_frame))
        else report_value("usr_frame", $sampled(fault_expected) ? '0 : $sampled(exp_frame),
                          $sampled(usr_frame));
    a_end_rd_count: assert property (@(posedge usr_clk) disable iff (!usr_rst)
        ($fell(usr_sampling) && !fault_expected) |-> rd_pulses == num_channels)
        else report_value("RD# pulses", 128'(num_channels), 128'($sampled(rd_pulses)));
    a_fault_state: assert property (@(posedge usr_clk) disable iff (!usr_rst)
        $rose(usr_error_occur) |-> (!usr_ready && usr_frame == '0 && rd_pulses <= 1))
        else report_fail("fault left usr_ready, usr_frame or RD# count wrong");
    a_fault_reset: assert property (@(posedge usr_clk) disable iff (!usr_rst)
        $rose(usr_error_occur) |=> hw_reset)
        else report_fail("no chip reset pulse after a fault");

    // **************************************************
    // stimulus
    // **************************************************
    function automatic logic pick_signal(input int sel);
        case (sel)
            sel_ready:    return usr_ready;
            sel_sampling: return usr_sampling;
            sel_error:    return usr_error_occur;
            default:      return hw_busy;
        endcase
    endfunction

    task automatic end_run();
        $display("checks failed: %0d, timeouts: %0d", err_cnt, timeouts);
        if (err_cnt == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    task automatic wait_until(input int sel, input logic level, input int limit,
                              input string what);
        int n;
        n = 0;
        while (pick_signal(sel) !== level && n < limit) begin
            @(negedge usr_clk); // outputs settled here.
            n++;
        end
        if (pick_signal(sel) !== level) begin
            timeouts++;
            $display("timeout at %0t ns: %s not seen within %0d cycles", $time, what, limit);
            end_run();
        end
    endtask

    task automatic pulse_trigger();
        @(negedge usr_clk);
        trig_req = 1'b1;
        repeat (2) @(negedge usr_clk);
        trig_req = 1'b0;
    endtask

    task automatic convert(input logic expect_fault, input logic retrigger);
        fault_expected = expect_fault;
        pulse_trigger();
        wait_until(sel_sampling, 1'b1, 8, "usr_sampling rise after trigger");
        if (retrigger) begin
            pulse_trigger(); // must be ignored.
        end
        if (busy_stuck) begin
            wait_until(sel_busy, 1'b1, 10, "BUSY rise");
            wait_until(sel_error, 1'b1, conv_max_clks + 10, "error flag after stuck BUSY");
        end
        wait_until(sel_sampling, 1'b0, conv_max_clks + 60, "end of conversion");
        wait_until(sel_ready, 1'b1, 20, "usr_ready");
        repeat (2) @(negedge usr_clk);
    endtask

    initial begin
        repeat (3) @(negedge usr_clk);
        rst_req = 1'b1;
        wait_until(sel_ready, 1'b1, 20, "usr_ready after reset");
        convert(1'b0, 1'b1);
        no_busy_rise = 1'b1;
        convert(1'b1, 1'b0);
        no_busy_rise = 1'b0;
        convert(1'b0, 1'b0); // clears the error flag.
        busy_stuck = 1'b1;
        convert(1'b1, 1'b0);
        busy_stuck = 1'b0;
        convert(1'b0, 1'b0);
        no_first_data = 1'b1;
        convert(1'b1, 1'b0);
        no_first_data = 1'b0;
        convert(1'b0, 1'b0);
        end_run();
    end

endmodule

//--- all.f
adc_timing_pkg.sv
adc_types_pkg.sv
adc_pin_sync.sv
adc_reset_seq.sv
adc_conv_seq.sv
adc_chan_reader.sv
ad7606_ctrl.sv
tb_ad7606_ctrl.sv

//--- Makefile
TOP = tb_ad7606_ctrl

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timing -f all.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Simulation PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
